//--- hw/video_pkg.sv
package video_pkg;

    //////////////////////////////
    // Timing modes
    //////////////////////////////

    // Reserved code runs Pentagon timing
    typedef enum logic [1:0] {
        MODE_48K      = 2'b00,
        MODE_128K     = 2'b01,
        MODE_PENTAGON = 2'b10,
        MODE_RESERVED = 2'b11
    } video_mode_e;

    //////////////////////////////
    // Wishbone classic
    //////////////////////////////

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [12:0] adr;
        logic [7:0]  dat;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wb_rsp_t;

    // Bitmap plus attributes
    localparam int unsigned SCREEN_BYTES = 6912;

    // Mode register at offset 0, border at offset 1
    localparam logic [12:0] REG_BASE = 13'h1B00;

    //////////////////////////////
    // Video path
    //////////////////////////////

    typedef struct packed {
        logic [8:0] hcnt;
        logic [8:0] vcnt;
        logic       last_line;
    } beam_pos_t;

    typedef struct packed {
        logic [2:0] r;
        logic [2:0] g;
        logic [2:0] b;
    } rgb_t;

endpackage

//--- hw/pal_sync_generator.sv
`timescale 1ns/1ps

module pal_sync_generator #(
    parameter video_pkg::video_mode_e DEFAULT_MODE = video_pkg::MODE_48K
) (
    input  logic                   clk,
    input  logic                   reset,
    input  video_pkg::video_mode_e mode,
    input  video_pkg::rgb_t        pix,
    output video_pkg::beam_pos_t   pos,
    output video_pkg::rgb_t        rgb,
    output logic                   hsync,
    output logic                   vsync,
    output logic                   int_n
);
    import video_pkg::*;

    // All bounds are inclusive
    typedef struct packed {
        logic [8:0] end_h;
        logic [8:0] end_v;
        logic [8:0] hblank_b;
        logic [8:0] hblank_e;
        logic [8:0] hsync_b;
        logic [8:0] hsync_e;
        logic [8:0] vblank_b;
        logic [8:0] vblank_e;
        logic [8:0] vsync_b;
        logic [8:0] vsync_e;
        logic [8:0] int_line;
        logic [8:0] hint_b;
        logic [8:0] hint_e;
    } timing_t;

    function automatic timing_t timing_for(input video_mode_e m);
        timing_t t;
        case (m)
            MODE_48K:  t = '{9'd447, 9'd311, 9'd320, 9'd415, 9'd344, 9'd375,
                             9'd248, 9'd255, 9'd248, 9'd251, 9'd248, 9'd2, 9'd65};
            // Longer line and one line less per frame than the 48K
            MODE_128K: t = '{9'd455, 9'd310, 9'd320, 9'd415, 9'd344, 9'd375,
                             9'd248, 9'd255, 9'd248, 9'd251, 9'd248, 9'd2, 9'd65};
            default:   t = '{9'd447, 9'd319, 9'd328, 9'd391, 9'd328, 9'd359,
                             9'd240, 9'd255, 9'd240, 9'd243, 9'd239, 9'd318, 9'd389};
        endcase
        return t;
    endfunction

    logic [8:0]  hc;
    logic [8:0]  vc;
    timing_t     cur;
    video_mode_e cur_mode;
    logic        hblank;
    logic        vblank;

    //////////////////////////////
    // Beam counters
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            hc       <= 9'd0;
            vc       <= 9'd0;
            cur      <= timing_for(DEFAULT_MODE);
            cur_mode <= DEFAULT_MODE;
        end else if (hc == cur.end_h) begin
            hc <= 9'd0;
            if (vc == cur.end_v) begin
                vc <= 9'd0;
                // New timing only on the frame wrap
                if (mode != cur_mode) begin
                    cur_mode <= mode;
                    cur      <= timing_for(mode);
                end
            end else begin
                vc <= vc + 9'd1;
            end
        end else begin
            hc <= hc + 9'd1;
        end
    end

    assign pos = '{hcnt: hc, vcnt: vc, last_line: (vc == cur.end_v)};

    //////////////////////////////
    // Blanking, syncs and INT
    //////////////////////////////

    assign hblank = (hc >= cur.hblank_b) && (hc <= cur.hblank_e);
    assign vblank = (vc >= cur.vblank_b) && (vc <= cur.vblank_e);

    always_comb begin
        rgb   = pix;
        hsync = 1'b1;
        vsync = 1'b1;
        if (hblank || vblank) begin
            rgb = '0;
            if (hc >= cur.hsync_b && hc <= cur.hsync_e)
                hsync = 1'b0;
            if (vc >= cur.vsync_b && vc <= cur.vsync_e)
                vsync = 1'b0;
        end
    end

    // One interrupt line per frame
    assign int_n = !((vc == cur.int_line) && (hc >= cur.hint_b) && (hc <= cur.hint_e));

endmodule

//--- hw/video_regs.sv
`timescale 1ns/1ps

module video_regs #(
    parameter video_pkg::video_mode_e DEFAULT_MODE = video_pkg::MODE_48K
) (
    input  logic                   clk,
    input  logic                   reset,
    input  video_pkg::wb_req_t     bus_req,
    output video_pkg::wb_rsp_t     bus_rsp,
    input  logic [7:0]             ram_rd_data,
    output logic                   ram_we,
    output video_pkg::video_mode_e mode,
    output logic [2:0]             border
);
    import video_pkg::*;

    logic        ack_q;
    logic        start;
    logic        ram_sel;
    logic        mode_sel;
    logic        border_sel;
    video_mode_e mode_q;
    logic [2:0]  border_q;

    // Address decode
    assign ram_sel    = bus_req.adr < SCREEN_BYTES;
    assign mode_sel   = bus_req.adr == REG_BASE;
    assign border_sel = bus_req.adr == REG_BASE + 13'd1;

    // First cycle of a new access
    assign start  = bus_req.cyc && bus_req.stb && !ack_q;
    assign ram_we = start && bus_req.we && ram_sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q    <= 1'b0;
            mode_q   <= DEFAULT_MODE;
            border_q <= 3'd0;
        end else begin
            ack_q <= start;
            if (start && bus_req.we && mode_sel)
                mode_q <= video_mode_e'(bus_req.dat[1:0]);
            if (start && bus_req.we && border_sel)
                border_q <= bus_req.dat[2:0];
        end
    end

    // Read mux, address still held during ack
    always_comb begin
        bus_rsp.ack = ack_q;
        if (ram_sel)
            bus_rsp.dat = ram_rd_data;
        else if (mode_sel)
            bus_rsp.dat = {6'd0, mode_q};
        else if (border_sel)
            bus_rsp.dat = {5'd0, border_q};
        else
            bus_rsp.dat = 8'd0;
    end

    assign mode   = mode_q;
    assign border = border_q;

endmodule

//--- hw/screen_ram.sv
`timescale 1ns/1ps

module screen_ram (
    input  logic               clk,
    input  video_pkg::wb_req_t bus_req,
    input  logic               ram_we,
    output logic [7:0]         ram_rd_data,
    input  logic [12:0]        vid_addr,
    output logic [7:0]         vid_data
);
    import video_pkg::*;

    // 6144 bitmap bytes followed by 768 attribute bytes
    logic [7:0] mem [SCREEN_BYTES];

    //////////////////////////////
    // Bus port
    //////////////////////////////

    // Read first, write data shows on the next access
    always_ff @(posedge clk) begin
        if (ram_we)
            mem[bus_req.adr] <= bus_req.dat;
        ram_rd_data <= mem[bus_req.adr];
    end

    //////////////////////////////
    // Video port
    //////////////////////////////

    // One cycle latency, never stalls the bus
    always_ff @(posedge clk) begin
        vid_data <= mem[vid_addr];
    end

endmodule

//--- hw/pixel_fetch.sv
`timescale 1ns/1ps

module pixel_fetch (
    input  logic                 clk,
    input  logic                 reset,
    input  video_pkg::beam_pos_t pos,
    input  logic [2:0]           border,
    output logic [12:0]          vid_addr,
    input  logic [7:0]           vid_data,
    output video_pkg::rgb_t      pix
);
    import video_pkg::*;

    logic [2:0]  sub;
    logic [8:0]  fetch_row;
    logic [4:0]  fetch_col;
    logic        fetch_en;
    logic [12:0] bmp_addr;
    logic [12:0] attr_addr;
    logic [7:0]  bmp_lat;
    logic [7:0]  attr_lat;
    logic [7:0]  shift_q;
    logic [7:0]  attr_q;
    logic        in_display;
    logic [2:0]  colour;
    logic [2:0]  level;

    assign sub = pos.hcnt[2:0];

    //////////////////////////////
    // Fetch one cell ahead
    //////////////////////////////

    always_comb begin
        if (pos.hcnt < 9'd256) begin
            fetch_row = pos.vcnt;
            fetch_col = pos.hcnt[7:3] + 5'd1;
        end else begin
            // Column 0 of the next row, row 0 after the last line
            fetch_row = pos.last_line ? 9'd0 : pos.vcnt + 9'd1;
            fetch_col = 5'd0;
        end
    end

    assign fetch_en = ((pos.hcnt < 9'd248) || (pos.hcnt >= 9'd256 && pos.hcnt < 9'd264))
                      && (fetch_row < 9'd192);

    // Interleaved layout y7y6 y2y1y0 y5y4y3 x4..x0
    assign bmp_addr  = {fetch_row[7:6], fetch_row[2:0], fetch_row[5:3], fetch_col};
    assign attr_addr = 13'd6144 + {3'd0, fetch_row[7:3], fetch_col};

    // Bitmap on sub 0, attribute from sub 1 on
    assign vid_addr = (sub == 3'd0) ? bmp_addr : attr_addr;

    always_ff @(posedge clk) begin
        if (fetch_en && sub == 3'd1)
            bmp_lat <= vid_data;
        if (fetch_en && sub == 3'd2)
            attr_lat <= vid_data;
    end

    //////////////////////////////
    // Shifter and attribute
    //////////////////////////////

    // Load entering each cell, border cells past 263 reload the same bytes
    always_ff @(posedge clk) begin
        if (reset) begin
            shift_q <= 8'd0;
            attr_q  <= 8'd0;
        end else if (sub == 3'd7 && pos.hcnt != 9'd255) begin
            shift_q <= bmp_lat;
            attr_q  <= attr_lat;
        end else begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    assign in_display = (pos.hcnt < 9'd256) && (pos.vcnt < 9'd192);

    // Colour bits are G R B, flash bit ignored
    always_comb begin
        if (in_display) begin
            colour = shift_q[7] ? attr_q[2:0] : attr_q[5:3];
            level  = attr_q[6] ? 3'b111 : 3'b101;
        end else begin
            colour = border;
            level  = 3'b101;
        end
        pix.r = colour[1] ? level : 3'b000;
        pix.g = colour[2] ? level : 3'b000;
        pix.b = colour[0] ? level : 3'b000;
    end

endmodule

//--- hw/video_top.sv
`timescale 1ns/1ps

module video_top #(
    parameter video_pkg::video_mode_e DEFAULT_MODE = video_pkg::MODE_48K
) (
    input  logic               clk,
    input  logic               reset,
    input  video_pkg::wb_req_t bus_req,
    output video_pkg::wb_rsp_t bus_rsp,
    output video_pkg::rgb_t    rgb,
    output logic               hsync,
    output logic               vsync,
    output logic               int_n,
    output logic [8:0]         hcnt,
    output logic [8:0]         vcnt
);
    import video_pkg::*;

    logic        ram_we;
    logic [7:0]  ram_rd_data;
    video_mode_e mode;
    logic [2:0]  border;
    logic [12:0] vid_addr;
    logic [7:0]  vid_data;
    beam_pos_t   pos;
    rgb_t        pix;

    //////////////////////////////
    // Host side
    //////////////////////////////

    video_regs #(
        .DEFAULT_MODE(DEFAULT_MODE)
    ) video_regs_inst (
        .clk        (clk),
        .reset      (reset),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .ram_rd_data(ram_rd_data),
        .ram_we     (ram_we),
        .mode       (mode),
        .border     (border)
    );

    screen_ram screen_ram_inst (
        .clk        (clk),
        .bus_req    (bus_req),
        .ram_we     (ram_we),
        .ram_rd_data(ram_rd_data),
        .vid_addr   (vid_addr),
        .vid_data   (vid_data)
    );

    //////////////////////////////
    // Video side
    //////////////////////////////

    pixel_fetch pixel_fetch_inst (
        .clk     (clk),
        .reset   (reset),
        .pos     (pos),
        .border  (border),
        .vid_addr(vid_addr),
        .vid_data(vid_data),
        .pix     (pix)
    );

    pal_sync_generator #(
        .DEFAULT_MODE(DEFAULT_MODE)
    ) pal_sync_generator_inst (
        .clk  (clk),
        .reset(reset),
        .mode (mode),
        .pix  (pix),
        .pos  (pos),
        .rgb  (rgb),
        .hsync(hsync),
        .vsync(vsync),
        .int_n(int_n)
    );

    assign hcnt = pos.hcnt;
    assign vcnt = pos.vcnt;

endmodule

//--- test/video_checker.sv
`timescale 1ns/1ps

module video_checker (
    input  logic               clk,
    input  logic               reset,
    input  video_pkg::wb_req_t bus_req,
    input  video_pkg::rgb_t    rgb,
    input  logic               hsync,
    input  logic               vsync,
    input  logic               int_n,
    input  logic [8:0]         hcnt,
    input  logic [8:0]         vcnt,
    input  logic               meas_start,
    input  logic               pix_start,
    input  logic               wrap_start,
    input  int                 exp_line,
    input  int                 exp_frame,
    input  int                 exp_hs,
    input  int                 exp_vs,
    input  int                 exp_int,
    input  int                 exp_old_frame,
    output logic               meas_done,
    output logic               pix_done,
    output logic               wrap_done,
    output int                 timing_errors,
    output int                 pixel_errors
);
    import video_pkg::*;

    // 48K geometry of the pixel frame
    localparam int LINE_CLOCKS = 448;
    localparam int FRAME_LINES = 312;

    logic [7:0] model_mem [SCREEN_BYTES];
    logic [2:0] border_model;
    logic       prev_hs;
    logic       prev_vs;
    logic       prev_int;
    logic       have_hs;
    int         meas_state;
    int         per_cnt;
    int         hs_low;
    int         lines;
    int         vs_lines;
    int         int_cnt;
    int         int_low;
    int         wrap_state;
    int         vmax;
    int         pix_state;
    int         pix_count;

    //////////////////////////////
    // Memory and border model
    //////////////////////////////

    // Written on the first cycle of each write access
    always @(negedge clk) begin
        if (!reset && bus_req.cyc && bus_req.stb && bus_req.we) begin
            if (bus_req.adr < 13'd6912)
                model_mem[bus_req.adr] = bus_req.dat;
            else if (bus_req.adr == REG_BASE + 13'd1)
                border_model = bus_req.dat[2:0];
        end
    end

    // Expected colour at a beam position with 48K blanking
    function automatic rgb_t expect_rgb(input int x, input int y);
        int         col;
        int         bmp_a;
        int         attr_a;
        logic [7:0] bmp;
        logic [7:0] attr;
        logic [2:0] c;
        logic [2:0] lvl;
        rgb_t       e;
        c   = border_model;
        lvl = 3'b101;
        if (x < 256 && y < 192) begin
            col    = x / 8;
            bmp_a  = ((y / 64) << 11) | ((y % 8) << 8) | (((y / 8) % 8) << 5) | col;
            attr_a = 6144 + (y / 8) * 32 + col;
            bmp    = model_mem[bmp_a];
            attr   = model_mem[attr_a];
            c      = bmp[7 - (x % 8)] ? attr[2:0] : attr[5:3];
            lvl    = attr[6] ? 3'b111 : 3'b101;
        end else if ((x >= 320 && x <= 415) || (y >= 248 && y <= 255)) begin
            c = 3'b000;
        end
        // Spectrum colour order is G R B
        e.r = c[1] ? lvl : 3'b000;
        e.g = c[2] ? lvl : 3'b000;
        e.b = c[0] ? lvl : 3'b000;
        return e;
    endfunction

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            timing_errors++;
            $display("** Error @ %0t: %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    //////////////////////////////
    // Timing measurement
    //////////////////////////////

    always @(negedge clk) begin
        if (reset) begin
            meas_state    = 0;
            wrap_state    = 0;
            meas_done     = 1'b0;
            wrap_done     = 1'b0;
            timing_errors = 0;
            prev_hs       = 1'b1;
            prev_vs       = 1'b1;
            prev_int      = 1'b1;
        end else begin
            if (meas_start) begin
                meas_state = 1;
                meas_done  = 1'b0;
            end else if (meas_state == 1 && prev_vs && !vsync) begin
                meas_state = 2;
                per_cnt    = 0;
                hs_low     = 0;
                lines      = 0;
                vs_lines   = 0;
                int_cnt    = 0;
                int_low    = 0;
                have_hs    = 1'b0;
            end else if (meas_state == 2) begin
                if (prev_hs && !hsync) begin
                    if (have_hs)
                        compare_count("hsync period", per_cnt, exp_line);
                    have_hs = 1'b1;
                    per_cnt = 0;
                    hs_low  = 0;
                    lines++;
                    if (!vsync)
                        vs_lines++;
                end
                per_cnt++;
                if (!hsync)
                    hs_low++;
                if (!prev_hs && hsync && have_hs)
                    compare_count("hsync low clocks", hs_low, exp_hs);
                if (prev_int && !int_n) begin
                    int_cnt++;
                    int_low = 0;
                end
                if (!int_n)
                    int_low++;
                if (!prev_int && int_n)
                    compare_count("int_n low clocks", int_low, exp_int);
                if (!prev_vs && vsync)
                    compare_count("vsync low lines", vs_lines, exp_vs);
                if (prev_vs && !vsync) begin
                    compare_count("lines per frame", lines, exp_frame);
                    compare_count("int_n pulses per frame", int_cnt, 1);
                    meas_state = 0;
                    meas_done  = 1'b1;
                end
            end

            // Frame length seen through the counters around a mode switch
            if (wrap_start) begin
                wrap_state = 1;
                wrap_done  = 1'b0;
                vmax       = int'(vcnt);
            end else if (wrap_state != 0) begin
                if (hcnt == 9'd0 && vcnt == 9'd0) begin
                    if (wrap_state == 1) begin
                        compare_count("frame lines before switch", vmax + 1, exp_old_frame);
                        wrap_state = 2;
                    end else begin
                        compare_count("frame lines after switch", vmax + 1, exp_frame);
                        wrap_state = 0;
                        wrap_done  = 1'b1;
                    end
                    vmax = 0;
                end else if (int'(vcnt) > vmax) begin
                    vmax = int'(vcnt);
                end
            end
            prev_hs  = hsync;
            prev_vs  = vsync;
            prev_int = int_n;
        end
    end

    //////////////////////////////
    // Pixel colour over one frame
    //////////////////////////////

    always @(negedge clk) begin
        rgb_t exp;
        logic at_origin;
        if (reset) begin
            pix_state    = 0;
            pix_done     = 1'b0;
            pixel_errors = 0;
        end else begin
            at_origin = (hcnt == 9'd0) && (vcnt == 9'd0);
            if (pix_start) begin
                pix_state = 1;
                pix_done  = 1'b0;
                pix_count = 0;
            end else if (pix_state == 2 && at_origin) begin
                if (pix_count != LINE_CLOCKS * FRAME_LINES) begin
                    pixel_errors++;
                    $display("** Error @ %0t: positions per frame expected %0d got %0d",
                             $time, LINE_CLOCKS * FRAME_LINES, pix_count);
                end
                pix_state = 0;
                pix_done  = 1'b1;
            end else if (pix_state == 2 || (pix_state == 1 && at_origin)) begin
                pix_state = 2;
                // Counters advance by one every clock from the origin
                if (int'(hcnt) != pix_count % LINE_CLOCKS
                        || int'(vcnt) != pix_count / LINE_CLOCKS) begin
                    pixel_errors++;
                    $display("** Error @ %0t: hcnt,vcnt expected (%0d,%0d) got (%0d,%0d)",
                             $time, pix_count % LINE_CLOCKS, pix_count / LINE_CLOCKS,
                             hcnt, vcnt);
                end
                pix_count++;
                exp = expect_rgb(int'(hcnt), int'(vcnt));
                if (rgb !== exp) begin
                    pixel_errors++;
                    $display("** Error @ %0t: rgb at (%0d,%0d) expected %h got %h",
                             $time, hcnt, vcnt, exp, rgb);
                end
            end
        end
    end

endmodule

//--- test/tb_video_top.sv
`timescale 1ns/1ps

module tb_video_top;
    import video_pkg::*;

    localparam int BUS_TIMEOUT  = 16;
    localparam int WAIT_TIMEOUT = 400000;

    typedef struct packed {
        video_mode_e mode;
        int          line;
        int          frame;
        int          hs;
        int          vs;
        int          intw;
    } entry_t;

    // Mode, clocks per line, lines per frame, hsync, vsync lines, int_n
    localparam entry_t MODES [4] = '{
        '{MODE_48K,      448, 312, 32, 4, 64},
        '{MODE_128K,     456, 311, 32, 4, 64},
        '{MODE_PENTAGON, 448, 320, 32, 4, 72},
        '{MODE_RESERVED, 448, 320, 32, 4, 72}
    };

    localparam logic [12:0] SCREEN_ADDRS [8] = '{
        13'd0, 13'd1, 13'd255, 13'd2048, 13'd4095, 13'd6143, 13'd6144, 13'd6911
    };

    logic       clk;
    logic       reset;
    wb_req_t    bus_req;
    wb_rsp_t    bus_rsp;
    rgb_t       rgb;
    logic       hsync;
    logic       vsync;
    logic       int_n;
    logic [8:0] hcnt;
    logic [8:0] vcnt;
    logic       meas_start;
    logic       pix_start;
    logic       wrap_start;
    logic       meas_done;
    logic       pix_done;
    logic       wrap_done;
    int         exp_line;
    int         exp_frame;
    int         exp_hs;
    int         exp_vs;
    int         exp_int;
    int         exp_old_frame;
    int         timing_errors;
    int         pixel_errors;
    int         bus_errors;
    int         timeouts;
    int         seed;
    int         rnd;
    logic [7:0] wvals [8];
    logic [7:0] mode_val;
    logic [7:0] border_val;

    video_top #(
        .DEFAULT_MODE(MODE_48K)
    ) video_top_inst (
        .clk    (clk),
        .reset  (reset),
        .bus_req(bus_req),
        .bus_rsp(bus_rsp),
        .rgb    (rgb),
        .hsync  (hsync),
        .vsync  (vsync),
        .int_n  (int_n),
        .hcnt   (hcnt),
        .vcnt   (vcnt)
    );

    video_checker video_checker_inst (
        .clk          (clk),
        .reset        (reset),
        .bus_req      (bus_req),
        .rgb          (rgb),
        .hsync        (hsync),
        .vsync        (vsync),
        .int_n        (int_n),
        .hcnt         (hcnt),
        .vcnt         (vcnt),
        .meas_start   (meas_start),
        .pix_start    (pix_start),
        .wrap_start   (wrap_start),
        .exp_line     (exp_line),
        .exp_frame    (exp_frame),
        .exp_hs       (exp_hs),
        .exp_vs       (exp_vs),
        .exp_int      (exp_int),
        .exp_old_frame(exp_old_frame),
        .meas_done    (meas_done),
        .pix_done     (pix_done),
        .wrap_done    (wrap_done),
        .timing_errors(timing_errors),
        .pixel_errors (pixel_errors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////
    // Wishbone driver
    //////////////////////////////

    task automatic bus_access(input logic we, input logic [12:0] adr,
                              input logic [7:0] wdat, output logic [7:0] rdat);
        int n;
        rdat = 8'd0;
        @(posedge clk);
        #1;
        bus_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        for (n = 0; n < BUS_TIMEOUT; n++) begin
            @(posedge clk);
            #1;
            if (bus_rsp.ack)
                break;
        end
        if (n == BUS_TIMEOUT) begin
            timeouts++;
            $display("Wishbone access to %h was never acknowledged", adr);
        end
        rdat    = bus_rsp.dat;
        bus_req = '0;
        @(posedge clk);
        #1;
        if (bus_rsp.ack) begin
            bus_errors++;
            $display("Wishbone ack to %h stayed high for more than one cycle", adr);
        end
    endtask

    task automatic bus_write(input logic [12:0] adr, input logic [7:0] dat);
        logic [7:0] unused;
        bus_access(1'b1, adr, dat, unused);
    endtask

    task automatic check_read(input logic [12:0] adr, input logic [7:0] exp);
        logic [7:0] got;
        bus_access(1'b0, adr, 8'd0, got);
        if (got !== exp) begin
            bus_errors++;
            $display("** Error @ %0t: bus_rsp.dat at %h expected %h got %h",
                     $time, adr, exp, got);
        end
    endtask

    //////////////////////////////
    // Bounded waits
    //////////////////////////////

    task automatic wait_vsync_fall();
        logic prev;
        int   n;
        prev = vsync;
        for (n = 0; n < WAIT_TIMEOUT; n++) begin
            @(negedge clk);
            if (prev && !vsync)
                break;
            prev = vsync;
        end
        if (n == WAIT_TIMEOUT) begin
            timeouts++;
            $display("Timed out waiting for a vsync falling edge");
        end
    endtask

    task automatic wait_line(input int line);
        int n;
        for (n = 0; n < WAIT_TIMEOUT; n++) begin
            @(negedge clk);
            if (int'(vcnt) == line && hcnt == 9'd0)
                break;
        end
        if (n == WAIT_TIMEOUT) begin
            timeouts++;
            $display("Timed out waiting for line %0d", line);
        end
    endtask

    function automatic logic done_flag(input int which);
        case (which)
            0:       return meas_done;
            1:       return pix_done;
            default: return wrap_done;
        endcase
    endfunction

    // Pulse a checker request and wait for its done flag
    task automatic run_check(input int which, input string what);
        int n;
        @(posedge clk);
        #1;
        meas_start = (which == 0);
        pix_start  = (which == 1);
        wrap_start = (which == 2);
        @(posedge clk);
        #1;
        meas_start = 1'b0;
        pix_start  = 1'b0;
        wrap_start = 1'b0;
        for (n = 0; n < WAIT_TIMEOUT; n++) begin
            @(posedge clk);
            if (done_flag(which))
                break;
        end
        if (n == WAIT_TIMEOUT) begin
            timeouts++;
            $display("Timed out waiting for the %s check", what);
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        bus_req       = '0;
        reset         = 1'b1;
        meas_start    = 1'b0;
        pix_start     = 1'b0;
        wrap_start    = 1'b0;
        exp_line      = 0;
        exp_frame     = 0;
        exp_hs        = 0;
        exp_vs        = 0;
        exp_int       = 0;
        exp_old_frame = 0;
        bus_errors    = 0;
        timeouts      = 0;
        seed          = 32'hb4a500bc;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        // Bus write and read back
        for (int i = 0; i < 8; i++) begin
            rnd      = $random(seed);
            wvals[i] = rnd[7:0];
            bus_write(SCREEN_ADDRS[i], wvals[i]);
        end
        rnd        = $random(seed);
        border_val = rnd[7:0];
        bus_write(REG_BASE + 13'd1, border_val);
        rnd      = $random(seed);
        mode_val = rnd[7:0];
        bus_write(REG_BASE, mode_val);
        bus_write(13'h1C00, 8'hA5);
        for (int i = 0; i < 8; i++)
            check_read(SCREEN_ADDRS[i], wvals[i]);
        check_read(REG_BASE + 13'd1, {5'd0, border_val[2:0]});
        check_read(REG_BASE, {6'd0, mode_val[1:0]});
        check_read(13'h1C00, 8'd0);
        bus_write(REG_BASE, 8'(MODE_48K));
        wait_vsync_fall();
        wait_vsync_fall();

        // Fill the whole screen and check one frame of pixels, border and blanking
        for (int a = 0; a < SCREEN_BYTES; a++) begin
            rnd = $random(seed);
            bus_write(13'(a), rnd[7:0]);
        end
        rnd = $random(seed);
        bus_write(REG_BASE + 13'd1, {5'd0, rnd[2:1], 1'b1});
        run_check(1, "pixel frame");

        // Frame geometry per mode
        for (int i = 0; i < 4; i++) begin
            bus_write(REG_BASE, 8'(MODES[i].mode));
            wait_vsync_fall();
            wait_vsync_fall();
            exp_line  = MODES[i].line;
            exp_frame = MODES[i].frame;
            exp_hs    = MODES[i].hs;
            exp_vs    = MODES[i].vs;
            exp_int   = MODES[i].intw;
            run_check(0, "frame timing");
        end

        // Mid-frame switch from Pentagon timing to 128K
        wait_line(100);
        bus_write(REG_BASE, 8'(MODE_128K));
        exp_old_frame = 320;
        exp_frame     = 311;
        run_check(2, "deferred mode change");

        $display("Errors: bus %0d, timing %0d, pixel %0d, timeouts %0d",
                 bus_errors, timing_errors, pixel_errors, timeouts);
        if (bus_errors + timing_errors + pixel_errors + timeouts == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- compile.f
hw/video_pkg.sv
hw/pal_sync_generator.sv
hw/video_regs.sv
hw/screen_ram.sv
hw/pixel_fetch.sv
hw/video_top.sv
test/video_checker.sv
test/tb_video_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the video subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_video_top \
    -Mdir obj_dir -o sim_video > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_video > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
    exit 0
fi
exit 1
